// File: Bender.yml
package:
  name: chip8_core

sources:
  - design/chip8_pkg.sv
  - design/chip8_alu.sv
  - design/call_stack.sv
  - design/chip8_core.sv
  - design/program_loader.sv
  - design/program_ram.sv
  - design/chip8_top.sv
  - target: test
    files:
      - tb/chip8_checker.sv
      - tb/chip8_tb.sv

// File: design/call_stack.sv
// return-address stack of STACK_DEPTH entries
// push when full or pop when empty is refused and reported on o_fault
// o_top is undefined while the stack is empty
module call_stack (
    input  logic              Chip8CLK,
    input  logic              i_rst_n,
    input  logic              i_clear,
    input  logic              i_push,
    input  logic              i_pop,
    input  chip8_pkg::addr_t  i_ret_addr,
    output chip8_pkg::addr_t  o_top,
    output logic              o_fault
);

    chip8_pkg::addr_t entries [chip8_pkg::STACK_DEPTH];
    // entry count, one bit wider than the index
    logic [chip8_pkg::STACK_PTR_W:0]   sp;
    logic [chip8_pkg::STACK_PTR_W-1:0] top_idx;
    logic full;
    logic empty;

    assign full    = (sp == (chip8_pkg::STACK_PTR_W + 1)'(chip8_pkg::STACK_DEPTH));
    assign empty   = (sp == '0);
    assign top_idx = sp[chip8_pkg::STACK_PTR_W-1:0] - 1'b1;
    assign o_top   = entries[top_idx];

    // same-cycle fault so the core can halt on this instruction
    assign o_fault = (i_push && full) || (i_pop && empty);

    always_ff @(posedge Chip8CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sp <= '0;
        end else if (i_clear) begin
            sp <= '0;
        end else if (i_push && !full) begin
            sp <= sp + 1'b1;
        end else if (i_pop && !empty) begin
            sp <= sp - 1'b1;
        end
    end

    // entry storage, no reset
    always_ff @(posedge Chip8CLK) begin
        if (i_push && !full && !i_clear) begin
            entries[sp[chip8_pkg::STACK_PTR_W-1:0]] <= i_ret_addr;
        end
    end

    // the core decodes one instruction at a time
    a_no_push_pop: assert property (
        @(posedge Chip8CLK) disable iff (!i_rst_n)
        !(i_push && i_pop)
    ) else $error("stack push and pop in the same cycle");

endmodule

// File: design/chip8_alu.sv
// 8xy operation unit, purely combinational
// shifts take their operand from rY
// flag: carry on ADD, not-borrow on SUB/SUBN, shifted-out bit on shifts
module chip8_alu (
    input  chip8_pkg::alu_op_e  i_op,
    input  chip8_pkg::byte_t    i_rx,
    input  chip8_pkg::byte_t    i_ry,
    output chip8_pkg::byte_t    o_result,
    output logic                o_flag,
    output logic                o_flag_we,
    output logic                o_illegal
);

    // one extra bit for carry / borrow
    logic [chip8_pkg::BYTE_W:0] wide;

    always_comb begin
        wide      = '0;
        o_result  = i_ry;
        o_flag    = 1'b0;
        o_flag_we = 1'b0;
        o_illegal = 1'b0;
        case (i_op)
            chip8_pkg::ALU_MOV: o_result = i_ry;
            chip8_pkg::ALU_OR:  o_result = i_rx | i_ry;
            chip8_pkg::ALU_AND: o_result = i_rx & i_ry;
            chip8_pkg::ALU_XOR: o_result = i_rx ^ i_ry;
            chip8_pkg::ALU_ADD: begin
                wide      = {1'b0, i_rx} + {1'b0, i_ry};
                o_result  = wide[chip8_pkg::BYTE_W-1:0];
                o_flag    = wide[chip8_pkg::BYTE_W];
                o_flag_we = 1'b1;
            end
            chip8_pkg::ALU_SUB: begin
                // top bit set means a borrow
                wide      = {1'b0, i_rx} - {1'b0, i_ry};
                o_result  = wide[chip8_pkg::BYTE_W-1:0];
                o_flag    = !wide[chip8_pkg::BYTE_W];
                o_flag_we = 1'b1;
            end
            chip8_pkg::ALU_SHR: begin
                o_result  = i_ry >> 1;
                o_flag    = i_ry[0];
                o_flag_we = 1'b1;
            end
            chip8_pkg::ALU_SUBN: begin
                wide      = {1'b0, i_ry} - {1'b0, i_rx};
                o_result  = wide[chip8_pkg::BYTE_W-1:0];
                o_flag    = !wide[chip8_pkg::BYTE_W];
                o_flag_we = 1'b1;
            end
            chip8_pkg::ALU_SHL: begin
                o_result  = i_ry << 1;
                o_flag    = i_ry[chip8_pkg::BYTE_W-1];
                o_flag_we = 1'b1;
            end
            // nibbles 8..D and F
            default: o_illegal = 1'b1;
        endcase
    end

endmodule

// File: design/chip8_core.sv
// CHIP-8 fetch/execute sequencer
// two cycles per instruction, o_pc moves only at the end of execute
// no display, keys, timers, RNG or I register; those opcodes raise o_err
// o_err halts the core until the next clear
module chip8_core (
    input  logic                Chip8CLK,
    input  logic                i_rst_n,
    input  logic                i_clear,
    input  logic                i_run,
    input  chip8_pkg::opcode_t  i_opcode,
    output chip8_pkg::addr_t    o_pc,
    output logic                o_err
);

    chip8_pkg::byte_t    regs [chip8_pkg::NUM_REGS];
    logic                exec_phase;
    logic                execute;

    // opcode fields
    logic [3:0]          op_leader;
    chip8_pkg::reg_sel_t x_sel;
    chip8_pkg::reg_sel_t y_sel;
    logic [3:0]          op_nibble;
    chip8_pkg::byte_t    op_const;
    chip8_pkg::addr_t    op_addr;

    chip8_pkg::byte_t    rx_val;
    chip8_pkg::byte_t    ry_val;
    chip8_pkg::addr_t    pc_plus2;
    chip8_pkg::addr_t    pc_plus4;
    chip8_pkg::addr_t    next_pc;
    chip8_pkg::addr_t    stack_top;

    // decode results
    logic                illegal;
    logic                push;
    logic                pop;
    logic                stack_fault;
    logic                wr_x;
    logic                wr_y;
    logic                wr_flag;
    chip8_pkg::byte_t    wr_data;

    // ALU
    chip8_pkg::alu_op_e  alu_op;
    logic                alu_shift;
    chip8_pkg::byte_t    alu_result;
    logic                alu_flag;
    logic                alu_flag_we;
    logic                alu_illegal;

    // Lxyn / Lxnn / Lnnn split
    assign op_leader = i_opcode[15:12];
    assign x_sel     = i_opcode[11:8];
    assign y_sel     = i_opcode[7:4];
    assign op_nibble = i_opcode[3:0];
    assign op_const  = i_opcode[7:0];
    assign op_addr   = i_opcode[11:0];

    assign rx_val   = regs[x_sel];
    assign ry_val   = regs[y_sel];
    assign pc_plus2 = o_pc + chip8_pkg::addr_t'(2);
    assign pc_plus4 = o_pc + chip8_pkg::addr_t'(4);

    // opcode is valid from the RAM only in the second cycle
    assign execute = i_run && !o_err && exec_phase;

    assign alu_op    = chip8_pkg::alu_op_e'(op_nibble);
    // shifts write the result back to rY too
    assign alu_shift = (alu_op == chip8_pkg::ALU_SHR) || (alu_op == chip8_pkg::ALU_SHL);

    chip8_alu u_alu (
        .i_op      (alu_op),
        .i_rx      (rx_val),
        .i_ry      (ry_val),
        .o_result  (alu_result),
        .o_flag    (alu_flag),
        .o_flag_we (alu_flag_we),
        .o_illegal (alu_illegal)
    );

    call_stack u_stack (
        .Chip8CLK   (Chip8CLK),
        .i_rst_n    (i_rst_n),
        .i_clear    (i_clear),
        .i_push     (execute && push),
        .i_pop      (execute && pop),
        .i_ret_addr (pc_plus2),
        .o_top      (stack_top),
        .o_fault    (stack_fault)
    );

    always_comb begin
        next_pc = pc_plus2;
        illegal = 1'b0;
        push    = 1'b0;
        pop     = 1'b0;
        wr_x    = 1'b0;
        wr_y    = 1'b0;
        wr_flag = 1'b0;
        wr_data = op_const;
        case (op_leader)
            4'h0: begin
                // only 00EE survives, 00E0 has no screen to clear
                if (i_opcode == 16'h00EE) begin
                    pop     = 1'b1;
                    next_pc = stack_top;
                end else begin
                    illegal = 1'b1;
                end
            end
            4'h1: next_pc = op_addr;
            4'h2: begin
                push    = 1'b1;
                next_pc = op_addr;
            end
            4'h3: if (rx_val == op_const) next_pc = pc_plus4;
            4'h4: if (rx_val != op_const) next_pc = pc_plus4;
            4'h5: begin
                illegal = (op_nibble != 4'h0);
                if (rx_val == ry_val) next_pc = pc_plus4;
            end
            4'h6: wr_x = 1'b1;
            4'h7: begin
                // carry is dropped, rF untouched
                wr_x    = 1'b1;
                wr_data = rx_val + op_const;
            end
            4'h8: begin
                illegal = alu_illegal;
                wr_x    = 1'b1;
                wr_y    = alu_shift;
                wr_flag = alu_flag_we;
                wr_data = alu_result;
            end
            4'h9: begin
                illegal = (op_nibble != 4'h0);
                if (rx_val != ry_val) next_pc = pc_plus4;
            end
            4'hB: next_pc = op_addr + chip8_pkg::addr_t'(regs[0]);
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge Chip8CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc       <= chip8_pkg::PROG_START;
            o_err      <= 1'b0;
            exec_phase <= 1'b0;
            for (int i = 0; i < chip8_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_clear) begin
            o_pc       <= chip8_pkg::PROG_START;
            o_err      <= 1'b0;
            exec_phase <= 1'b0;
            for (int i = 0; i < chip8_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_run && !o_err) begin
            exec_phase <= !exec_phase;
            if (exec_phase) begin
                if (illegal || stack_fault) begin
                    // halt on the faulting instruction
                    o_err <= 1'b1;
                end else begin
                    o_pc <= next_pc;
                    if (wr_x) regs[x_sel] <= wr_data;
                    if (wr_y) regs[y_sel] <= wr_data;
                    // flag written last so it wins over rX = rF
                    if (wr_flag) begin
                        regs[chip8_pkg::FLAG_REG] <= {{(chip8_pkg::BYTE_W-1){1'b0}}, alu_flag};
                    end
                end
            end
        end else begin
            exec_phase <= 1'b0;
        end
    end

    // a halted core keeps its PC until reloaded
    a_pc_frozen_on_err: assert property (
        @(posedge Chip8CLK) disable iff (!i_rst_n)
        (o_err && !i_clear) |=> $stable(o_pc)
    ) else $error("o_pc moved while o_err is high");

endmodule

// File: design/chip8_pkg.sv
// shared widths, limits and types of the CHIP-8 core
// memory is a flat 4096-byte space, programs start at 0x200
// no font area, no I register, no timers
package chip8_pkg;

    // data and address widths
    localparam int BYTE_W = 8;
    localparam int ADDR_W = 12;

    // memory map
    localparam int MEM_BYTES = 4096;
    localparam logic [ADDR_W-1:0] PROG_START = 12'h200;

    // register file, rF carries the ALU flag
    localparam int NUM_REGS = 16;
    localparam int FLAG_REG = 15;

    // return-address stack
    localparam int STACK_DEPTH = 32;
    localparam int STACK_PTR_W = $clog2(STACK_DEPTH);

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [15:0] opcode_t;
    typedef logic [3:0] reg_sel_t;

    // 8xy operations, value is the low opcode nibble
    typedef enum logic [3:0] {
        ALU_MOV  = 4'h0,
        ALU_OR   = 4'h1,
        ALU_AND  = 4'h2,
        ALU_XOR  = 4'h3,
        ALU_ADD  = 4'h4,
        ALU_SUB  = 4'h5,
        ALU_SHR  = 4'h6,
        ALU_SUBN = 4'h7,
        ALU_SHL  = 4'hE
    } alu_op_e;

endpackage

// File: design/chip8_top.sv
// CHIP-8 core with a streamed program load
// a load pulse stops the core, bytes go to RAM from 0x200 upward,
// the core runs from the cycle after the byte marked last
// o_pc and o_err stand in for the board LEDs
module chip8_top (
    input  logic              i_rst_n,
    input  logic              Chip8CLK,
    input  logic              i_load_start,
    input  logic              i_load_valid,
    input  chip8_pkg::byte_t  i_load_data,
    input  logic              i_load_last,
    output logic              o_load_ready,
    output chip8_pkg::addr_t  o_pc,
    output logic              o_err
);

    // loader to RAM write port
    logic              wr_en;
    chip8_pkg::addr_t  wr_addr;
    chip8_pkg::byte_t  wr_data;

    // loader to core control
    logic              core_clear;
    logic              core_run;

    // opcode read back at the PC
    chip8_pkg::opcode_t opcode;

    program_loader u_loader (
        .Chip8CLK     (Chip8CLK),
        .i_rst_n      (i_rst_n),
        .i_load_start (i_load_start),
        .i_load_valid (i_load_valid),
        .i_load_data  (i_load_data),
        .i_load_last  (i_load_last),
        .o_load_ready (o_load_ready),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_data    (wr_data),
        .o_core_clear (core_clear),
        .o_run        (core_run)
    );

    program_ram u_ram (
        .Chip8CLK  (Chip8CLK),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_addr (o_pc),
        .o_opcode  (opcode)
    );

    chip8_core u_core (
        .Chip8CLK (Chip8CLK),
        .i_rst_n  (i_rst_n),
        .i_clear  (core_clear),
        .i_run    (core_run),
        .i_opcode (opcode),
        .o_pc     (o_pc),
        .o_err    (o_err)
    );

endmodule

// File: design/program_loader.sv
// program byte stream to RAM writes
// ready rises the cycle after i_load_start and drops after the last byte
// a new start pulse restarts the load at 0x200 at any time
module program_loader (
    input  logic              Chip8CLK,
    input  logic              i_rst_n,
    input  logic              i_load_start,
    input  logic              i_load_valid,
    input  chip8_pkg::byte_t  i_load_data,
    input  logic              i_load_last,
    output logic              o_load_ready,
    output logic              o_wr_en,
    output chip8_pkg::addr_t  o_wr_addr,
    output chip8_pkg::byte_t  o_wr_data,
    output logic              o_core_clear,
    output logic              o_run
);

    logic              loading;
    logic              accept;
    chip8_pkg::addr_t  wr_addr;

    // a byte moves when valid meets ready
    assign accept       = loading && i_load_valid;
    assign o_load_ready = loading;

    // accepted bytes go straight to memory
    assign o_wr_en   = accept;
    assign o_wr_addr = wr_addr;
    assign o_wr_data = i_load_data;

    // core state is cleared in the start cycle itself
    assign o_core_clear = i_load_start;

    always_ff @(posedge Chip8CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            loading <= 1'b0;
            wr_addr <= chip8_pkg::PROG_START;
            o_run   <= 1'b0;
        end else if (i_load_start) begin
            // stop the core and rewind the write pointer
            loading <= 1'b1;
            wr_addr <= chip8_pkg::PROG_START;
            o_run   <= 1'b0;
        end else if (accept) begin
            wr_addr <= wr_addr + chip8_pkg::addr_t'(1);
            if (i_load_last) begin
                // hand over to the core on the next cycle
                loading <= 1'b0;
                o_run   <= 1'b1;
            end
        end
    end

    // the RAM is never written under a running program
    a_no_write_while_run: assert property (
        @(posedge Chip8CLK) disable iff (!i_rst_n)
        o_wr_en |-> !o_run
    ) else $error("program RAM written while the core runs");

endmodule

// File: design/program_ram.sv
// 4096-byte program memory
// one write port, one registered big-endian opcode read
// the second byte address wraps from 0xFFF to 0x000
// contents are undefined until a program is loaded
module program_ram (
    input  logic                Chip8CLK,
    input  logic                i_wr_en,
    input  chip8_pkg::addr_t    i_wr_addr,
    input  chip8_pkg::byte_t    i_wr_data,
    input  chip8_pkg::addr_t    i_rd_addr,
    output chip8_pkg::opcode_t  o_opcode
);

    chip8_pkg::byte_t mem [chip8_pkg::MEM_BYTES];
    chip8_pkg::addr_t rd_next;

    // low opcode byte, wraps with the 12-bit address
    assign rd_next = i_rd_addr + chip8_pkg::addr_t'(1);

    always_ff @(posedge Chip8CLK) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        // high byte first
        o_opcode <= {mem[i_rd_addr], mem[rd_next]};
    end

endmodule

// File: filelist.f
design/chip8_pkg.sv
design/chip8_alu.sv
design/call_stack.sv
design/chip8_core.sv
design/program_loader.sv
design/program_ram.sv
design/chip8_top.sv
tb/chip8_checker.sv
tb/chip8_tb.sv

// File: tb/chip8_cases.txt
# case <name> <byte count> <expected final pc, hex> <expected o_err>
# then the program bytes in hex, loaded from 0x200 upward
# jumps and skips, a wrong branch self-jumps at its own address
case jump_skip 34 220 0
60 05 70 03 30 08 12 06 40 08 12 0E 12 0C 61 08
50 10 12 12 90 10 12 1A 12 18 60 02 B2 1E 12 1E
12 20
# sprite draw is dropped and halts at 0x202
case draw_illegal 4 202 1
60 01 D0 15
# 8xy ops with carry and borrow edges, each failed check traps apart
case alu_flags 100 262 0
60 F0 61 20 80 14 30 10 12 08 3F 01 12 0C 62 05
63 07 82 35 32 FE 12 16 3F 00 12 1A 83 27 33 F7
12 20 3F 01 12 24 64 81 85 46 35 40 12 2C 34 40
12 30 3F 01 12 34 66 81 87 6E 37 02 12 3C 3F 01
12 40 68 C3 69 3C 88 91 38 FF 12 4A 68 C3 88 92
38 00 12 52 68 C3 88 93 38 FF 12 5A 8A 90 3A 3C
12 60 12 62
# a call to itself overflows the stack
case stack_overflow 2 200 1
22 00
# two nested calls
case call_return 20 212 0
22 08 30 05 12 04 12 12 22 0E 70 01 00 EE 60 04
00 EE 12 12
# register store through I is dropped
case store_illegal 6 204 1
61 03 71 01 F1 55
# return with an empty stack
case stack_underflow 2 200 1
00 EE
# reload after a fault must clear o_err
case reload_short 8 206 0
60 07 30 07 12 04 12 06

// File: tb/chip8_checker.sv
// watches o_pc, o_err and o_load_ready of the CHIP-8 top level
// values are sampled on the falling clock edge, away from register updates
// a case ends in a self-jump, so its final PC must hold for 20 instructions
module chip8_checker (
    input logic        Chip8CLK,
    input logic [11:0] i_pc,
    input logic        i_err,
    input logic        i_load_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // generous bound, the longest case runs about 100 cycles
    localparam int RUN_TIMEOUT = 4000;
    // 20 instruction periods of two cycles each
    localparam int HOLD_CYCLES = 40;

    int mismatches = 0;
    int problems = 0;

    // one compare, prints the signal with expected and actual in hex
    function automatic bit compare(input string sig, input logic [15:0] exp,
                                   input logic [15:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected 0x%0h got 0x%0h", sig, exp, act);
            mismatches++;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic report_problem(input string msg);
        $display("ERROR: %s", msg);
        problems++;
    endtask

    // idle state right after reset release
    task automatic check_after_reset();
        @(negedge Chip8CLK);
        void'(compare("o_load_ready", 16'h0, {15'h0, i_load_ready}));
        void'(compare("o_err", 16'h0, {15'h0, i_err}));
        void'(compare("o_pc", 16'h200, {4'h0, i_pc}));
    endtask

    // wait for the final PC and error flag, then confirm they are at rest
    task automatic wait_for_result(input string case_name, input logic [11:0] exp_pc,
                                   input logic exp_err);
        int  cycles;
        bit  done;
        bit  ok;
        cycles = 0;
        done   = 1'b0;
        ok     = 1'b1;
        while (!done && cycles < RUN_TIMEOUT) begin
            @(negedge Chip8CLK);
            // ready stays low for the whole run, junk bytes are on offer
            if (ok) ok = compare("o_load_ready", 16'h0, {15'h0, i_load_ready});
            done = (i_pc === exp_pc) && (i_err === exp_err);
            cycles++;
        end
        if (!done) begin
            report_problem($sformatf("case %s did not settle within %0d cycles",
                                     case_name, RUN_TIMEOUT));
            void'(compare("o_pc", {4'h0, exp_pc}, {4'h0, i_pc}));
            void'(compare("o_err", {15'h0, exp_err}, {15'h0, i_err}));
        end else begin
            // a wrong path would move on, a trap or the end state stays put
            for (int i = 0; i < HOLD_CYCLES && ok; i++) begin
                @(negedge Chip8CLK);
                ok = compare("o_pc", {4'h0, exp_pc}, {4'h0, i_pc})
                    && compare("o_err", {15'h0, exp_err}, {15'h0, i_err})
                    && compare("o_load_ready", 16'h0, {15'h0, i_load_ready});
            end
        end
    endtask

endmodule

// File: tb/chip8_tb.sv
// testbench for the CHIP-8 core, reads programs from tb/chip8_cases.txt
// each case loads over the byte stream with random idle gaps, then runs
// inputs change 2 ns after the rising edge
// junk bytes stay on offer during a run and must be ignored
module chip8_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int HS_TIMEOUT = 200;
    localparam int MAX_BYTES = 256;
    localparam CASE_FILE = "tb/chip8_cases.txt";
    localparam logic [31:0] LCG_SEED = 32'h59c6;

    logic        Chip8CLK;
    logic        i_rst_n;
    logic        i_load_start;
    logic        i_load_valid;
    logic [7:0]  i_load_data;
    logic        i_load_last;
    logic        o_load_ready;
    logic [11:0] o_pc;
    logic        o_err;

    logic [31:0] lcg_state;
    logic [7:0]  prog [MAX_BYTES];
    logic [7:0]  byte_val;
    logic [11:0] exp_pc;
    logic        exp_err;
    string       tok;
    string       case_name;
    string       rest;
    int          fd;
    int          code;
    int          count;
    int          num_cases;

    chip8_top i_dut (
        .i_rst_n      (i_rst_n),
        .Chip8CLK     (Chip8CLK),
        .i_load_start (i_load_start),
        .i_load_valid (i_load_valid),
        .i_load_data  (i_load_data),
        .i_load_last  (i_load_last),
        .o_load_ready (o_load_ready),
        .o_pc         (o_pc),
        .o_err        (o_err)
    );

    chip8_checker u_chk (
        .Chip8CLK     (Chip8CLK),
        .i_pc         (o_pc),
        .i_err        (o_err),
        .i_load_ready (o_load_ready)
    );

    initial begin
        Chip8CLK = 1'b0;
        forever #(CLK_PERIOD / 2) Chip8CLK = ~Chip8CLK;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_drive_slot();
        @(posedge Chip8CLK);
        #2;
    endtask

    // offer one byte after 0..3 idle cycles, hold it until ready takes it
    task automatic stream_byte(input logic [7:0] data, input logic last, input int idx);
        int   gap;
        int   waited;
        logic accepted;
        lcg_state = lcg_next(lcg_state);
        gap = int'(lcg_state[17:16]);
        i_load_valid = 1'b0;
        repeat (gap) next_drive_slot();
        i_load_valid = 1'b1;
        i_load_data  = data;
        i_load_last  = last;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < HS_TIMEOUT) begin
            // ready seen mid-cycle means the byte moves at the next edge
            @(negedge Chip8CLK);
            accepted = o_load_ready;
            next_drive_slot();
            waited++;
        end
        if (!accepted) begin
            u_chk.report_problem($sformatf("load byte %0d was never accepted", idx));
        end
        i_load_valid = 1'b0;
    endtask

    task automatic load_program(input int n);
        next_drive_slot();
        i_load_valid = 1'b0;
        i_load_start = 1'b1;
        next_drive_slot();
        i_load_start = 1'b0;
        for (int i = 0; i < n; i++) begin
            stream_byte(prog[i], i == n - 1, i);
        end
        // back-pressure check, these must not reach the RAM
        lcg_state = lcg_next(lcg_state);
        i_load_valid = 1'b1;
        i_load_data  = lcg_state[31:24];
        i_load_last  = lcg_state[0];
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_load_start = 1'b0;
        i_load_valid = 1'b0;
        i_load_data  = 8'h00;
        i_load_last  = 1'b0;
        lcg_state    = LCG_SEED;
        num_cases    = 0;
        repeat (16) @(posedge Chip8CLK);
        #2;
        i_rst_n = 1'b1;
        u_chk.check_after_reset();

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            u_chk.report_problem("the case file could not be opened");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[0] == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "case") begin
                    code = $fscanf(fd, "%s %d %h %h", case_name, count, exp_pc, exp_err);
                    if (code != 4 || count < 1 || count > MAX_BYTES) begin
                        u_chk.report_problem("a case header in the case file is malformed");
                        break;
                    end
                    for (int i = 0; i < count; i++) begin
                        code = $fscanf(fd, "%h", byte_val);
                        prog[i] = byte_val;
                    end
                    load_program(count);
                    u_chk.wait_for_result(case_name, exp_pc, exp_err);
                    num_cases++;
                end else begin
                    u_chk.report_problem($sformatf("unexpected word %s in the case file", tok));
                    break;
                end
            end
            $fclose(fd);
        end
        if (num_cases == 0) u_chk.report_problem("no case was run");

        $display("cases run %0d, mismatches %0d, other errors %0d",
                 num_cases, u_chk.mismatches, u_chk.problems);
        if (u_chk.mismatches == 0 && u_chk.problems == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
